// ==== common/lsu_defines.svh ====
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// physical address width of every L2 request
`define LSU_PADDR_W 32

// bytes in one L1D line
`define LSU_LINE_B_W 16

// L2 command tag, source prefix in the top two bits
`define LSU_L2_TAG_W 8

// miss identifier, lives in the low bits of a read tag
`define LSU_MISS_ID_W 2

// dirty lines that can wait for writeback
`define LSU_EVICT_BUF_DEPTH 2

`endif

// ==== common/lsu_pkg.sv ====
`include "lsu_defines.svh"

package lsu_pkg;

  // L2 request command
  typedef enum logic [1:0] {
    M_XRD = 2'b00,  // line read
    M_XWR = 2'b01   // full line write
  } l2_cmd_t;

  // source marks in the upper tag bits
  localparam logic [1:0] L2_UPPER_TAG_RD_L1D = 2'b01;
  localparam logic [1:0] L2_UPPER_TAG_WR_L1D = 2'b10;

  // dirty line leaving the cache
  typedef struct packed {
    logic [`LSU_PADDR_W-1:0]    paddr;
    logic [`LSU_LINE_B_W*8-1:0] data;
  } evict_payload_t;

  // line the cache needs refilled
  typedef struct packed {
    logic [`LSU_PADDR_W-1:0]   paddr;    // line aligned
    logic [`LSU_MISS_ID_W-1:0] miss_id;
  } miss_payload_t;

  // one request on the L2 channel
  typedef struct packed {
    l2_cmd_t                    cmd;
    logic [`LSU_PADDR_W-1:0]    addr;
    logic [`LSU_L2_TAG_W-1:0]   tag;
    logic [`LSU_LINE_B_W*8-1:0] data;
    logic [`LSU_LINE_B_W-1:0]   byte_en;
  } l2_req_payload_t;

endpackage

// ==== src/evict_buffer.sv ====
`timescale 1ns/1ns
`include "lsu_defines.svh"

module evict_buffer (
  input  logic                   i_clk,
  input  logic                   i_reset_n,

  input  logic                   in_valid,
  output logic                   in_ready,
  input  lsu_pkg::evict_payload_t in_payload,

  output logic                   out_valid,
  input  logic                   out_ready,
  output lsu_pkg::evict_payload_t out_payload
);

  import lsu_pkg::*;

  localparam int DEPTH = `LSU_EVICT_BUF_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  evict_payload_t   r_mem [DEPTH];
  logic [PTR_W-1:0] r_wr_ptr;
  logic [PTR_W-1:0] r_rd_ptr;
  logic [CNT_W-1:0] r_count;
  logic             push;
  logic             pop;

  assign in_ready    = (r_count != CNT_W'(DEPTH));
  assign out_valid   = (r_count != '0);
  assign out_payload = r_mem[r_rd_ptr];  // head entry

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (push) begin
        r_wr_ptr <= (r_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
      end
      if (pop) begin
        r_rd_ptr <= (r_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;  // idle or pass
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (push) begin
      r_mem[r_wr_ptr] <= in_payload;
    end
  end

  // the waiting head entry is never overwritten
  a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    out_valid && !out_ready |=> $stable(out_payload));

  // an empty buffer has both pointers on the same slot
  a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (r_count == '0) |-> (r_rd_ptr == r_wr_ptr));

endmodule

// ==== src/store_requestor.sv ====
`timescale 1ns/1ns
`include "lsu_defines.svh"

module store_requestor (
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  input  logic                     evict_valid,
  output logic                     evict_ready,
  input  lsu_pkg::evict_payload_t  evict_payload,

  output logic                     wr_req_valid,
  input  logic                     wr_req_ready,
  output lsu_pkg::l2_req_payload_t wr_req_payload
);

  import lsu_pkg::*;

  logic           r_skid_valid;
  evict_payload_t r_skid_payload;
  evict_payload_t sel_entry;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_skid_valid <= 1'b0;
    end else if (evict_valid & evict_ready & !wr_req_ready) begin
      r_skid_valid <= 1'b1;  // L2 stalled, park the line
    end else if (wr_req_ready) begin
      r_skid_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (evict_valid & evict_ready & !wr_req_ready) begin
      r_skid_payload <= evict_payload;
    end
  end

  assign evict_ready  = !r_skid_valid;
  assign wr_req_valid = evict_valid | r_skid_valid;
  assign sel_entry    = r_skid_valid ? r_skid_payload : evict_payload;

  always_comb begin
    wr_req_payload.cmd     = M_XWR;
    wr_req_payload.addr    = sel_entry.paddr;
    wr_req_payload.tag     = {L2_UPPER_TAG_WR_L1D, {(`LSU_L2_TAG_W - 2){1'b0}}};
    wr_req_payload.data    = sel_entry.data;
    wr_req_payload.byte_en = {`LSU_LINE_B_W{1'b1}};  // whole line written
  end

  // a waiting write holds its contents, whether from the FIFO head or the skid
  a_wr_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    wr_req_valid && !wr_req_ready |=> wr_req_valid && $stable(wr_req_payload));

endmodule

// ==== src/refill_requestor.sv ====
`timescale 1ns/1ns
`include "lsu_defines.svh"

module refill_requestor (
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  input  logic                     miss_valid,
  output logic                     miss_ready,
  input  lsu_pkg::miss_payload_t   miss_payload,

  output logic                     rd_req_valid,
  input  logic                     rd_req_ready,
  output lsu_pkg::l2_req_payload_t rd_req_payload
);

  import lsu_pkg::*;

  localparam int PAD_W = `LSU_L2_TAG_W - 2 - `LSU_MISS_ID_W;

  logic          r_valid;
  miss_payload_t r_miss;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else if (miss_valid & miss_ready) begin
      r_valid <= 1'b1;
    end else if (rd_req_ready) begin
      r_valid <= 1'b0;  // read went out
    end
  end

  always_ff @(posedge i_clk) begin
    if (miss_valid & miss_ready) begin
      r_miss <= miss_payload;
    end
  end

  assign miss_ready   = !r_valid;  // one miss at a time
  assign rd_req_valid = r_valid;

  // the miss id rides in the low tag bits so the refill can be matched
  always_comb begin
    rd_req_payload.cmd     = M_XRD;
    rd_req_payload.addr    = r_miss.paddr;
    rd_req_payload.tag     = {L2_UPPER_TAG_RD_L1D, {PAD_W{1'b0}}, r_miss.miss_id};
    rd_req_payload.data    = '0;
    rd_req_payload.byte_en = '0;
  end

endmodule

// ==== src/l2_req_arbiter.sv ====
`timescale 1ns/1ns

module l2_req_arbiter (
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  input  logic                     wr_valid,
  output logic                     wr_ready,
  input  lsu_pkg::l2_req_payload_t wr_payload,

  input  logic                     rd_valid,
  output logic                     rd_ready,
  input  lsu_pkg::l2_req_payload_t rd_payload,

  output logic                     l2_valid,
  input  logic                     l2_ready,
  output lsu_pkg::l2_req_payload_t l2_payload
);

  logic r_last_wr;  // write won the last grant
  logic r_lock;     // granted request still waiting
  logic sel_wr;

  always_comb begin
    if (r_lock) begin
      sel_wr = r_last_wr;  // hold the winner
    end else if (wr_valid && rd_valid) begin
      sel_wr = !r_last_wr;
    end else begin
      sel_wr = wr_valid;
    end
  end

  assign l2_valid   = sel_wr ? wr_valid : rd_valid;
  assign l2_payload = sel_wr ? wr_payload : rd_payload;
  assign wr_ready   = l2_ready & sel_wr;
  assign rd_ready   = l2_ready & !sel_wr;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_last_wr <= 1'b0;
      r_lock    <= 1'b0;
    end else if (l2_valid) begin
      r_last_wr <= sel_wr;
      r_lock    <= !l2_ready;
    end
  end

  // a waiting request keeps its source and its contents
  a_grant_held: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    l2_valid && !l2_ready |=> l2_valid && $stable(l2_payload));

endmodule

// ==== src/l1d_writeback_top.sv ====
`timescale 1ns/1ns

module l1d_writeback_top (
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  input  logic                     evict_valid,
  output logic                     evict_ready,
  input  lsu_pkg::evict_payload_t  evict_payload,

  input  logic                     miss_valid,
  output logic                     miss_ready,
  input  lsu_pkg::miss_payload_t   miss_payload,

  output logic                     l2_req_valid,
  input  logic                     l2_req_ready,
  output lsu_pkg::l2_req_payload_t l2_req_payload
);

  import lsu_pkg::*;

  logic            buf_valid;  // buffer head to store side
  logic            buf_ready;
  evict_payload_t  buf_payload;

  logic            wr_valid;
  logic            wr_ready;
  l2_req_payload_t wr_payload;

  logic            rd_valid;
  logic            rd_ready;
  l2_req_payload_t rd_payload;

  evict_buffer evict_buffer_i (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .in_valid    (evict_valid),
    .in_ready    (evict_ready),
    .in_payload  (evict_payload),
    .out_valid   (buf_valid),
    .out_ready   (buf_ready),
    .out_payload (buf_payload)
  );

  store_requestor store_requestor_i (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .evict_valid    (buf_valid),
    .evict_ready    (buf_ready),
    .evict_payload  (buf_payload),
    .wr_req_valid   (wr_valid),
    .wr_req_ready   (wr_ready),
    .wr_req_payload (wr_payload)
  );

  refill_requestor refill_requestor_i (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .miss_valid     (miss_valid),
    .miss_ready     (miss_ready),
    .miss_payload   (miss_payload),
    .rd_req_valid   (rd_valid),
    .rd_req_ready   (rd_ready),
    .rd_req_payload (rd_payload)
  );

  l2_req_arbiter l2_req_arbiter_i (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .wr_valid   (wr_valid),
    .wr_ready   (wr_ready),
    .wr_payload (wr_payload),
    .rd_valid   (rd_valid),
    .rd_ready   (rd_ready),
    .rd_payload (rd_payload),
    .l2_valid   (l2_req_valid),
    .l2_ready   (l2_req_ready),
    .l2_payload (l2_req_payload)
  );

endmodule

// ==== verification/tb_l1d_writeback.sv ====
`timescale 1ns/1ns
`include "lsu_defines.svh"

module tb_l1d_writeback;

  import lsu_pkg::*;

  localparam int CLK_NS = 100;
  localparam int ID_W   = `LSU_MISS_ID_W;
  // cycles per test: reset, single, back-pressure, refill, mixed
  localparam int BUDGET_CYCLES = 10 + 20 + 80 + 60 + 240;
  localparam int WATCHDOG_NS   = BUDGET_CYCLES * 4 * CLK_NS;

  logic            i_clk = 1'b0;
  logic            i_reset_n;
  logic            evict_valid;
  logic            evict_ready;
  evict_payload_t  evict_payload;
  logic            miss_valid;
  logic            miss_ready;
  miss_payload_t   miss_payload;
  logic            l2_req_valid;
  logic            l2_req_ready;
  l2_req_payload_t l2_req_payload;

  evict_payload_t  exp_wr[$];  // accepted lines not yet seen on L2
  miss_payload_t   exp_rd[$];
  int              errors;
  int              tests_run;
  int              tests_failed;
  bit              feed_done;  // all stimulus of a test handed over

  l1d_writeback_top l1d_writeback_top_i (.*);

  always #(CLK_NS / 2) i_clk = ~i_clk;

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

  task automatic note_error(string line);
    errors++;
    $display("%s", line);
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp) begin
      note_error($sformatf("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_write(l2_req_payload_t got, evict_payload_t exp);
    logic [`LSU_L2_TAG_W-1:0] tag;
    tag = {L2_UPPER_TAG_WR_L1D, {(`LSU_L2_TAG_W - 2){1'b0}}};
    if (got.cmd !== M_XWR || got.addr !== exp.paddr || got.tag !== tag ||
        got.data !== exp.data || got.byte_en !== '1) begin
      note_error($sformatf("Fail at %0t ns: write of line %h came out as cmd %0d addr %h tag %h",
                           $time, exp.paddr, got.cmd, got.addr, got.tag));
    end
  endtask

  task automatic check_read(l2_req_payload_t got, miss_payload_t exp);
    logic [`LSU_L2_TAG_W-1:0] tag;
    tag = {L2_UPPER_TAG_RD_L1D, {(`LSU_L2_TAG_W - 2 - ID_W){1'b0}}, exp.miss_id};
    if (got.cmd !== M_XRD || got.addr !== exp.paddr || got.tag !== tag ||
        got.data !== '0 || got.byte_en !== '0) begin
      note_error($sformatf("Fail at %0t ns: read of line %h came out as cmd %0d addr %h tag %h",
                           $time, exp.paddr, got.cmd, got.addr, got.tag));
    end
  endtask

  // sorts each accepted request by cmd and matches it against its source queue
  task automatic take_request(l2_req_payload_t req);
    if (req.cmd == M_XWR && exp_wr.size() != 0) begin
      check_write(req, exp_wr.pop_front());
    end else if (req.cmd == M_XRD && exp_rd.size() != 0) begin
      check_read(req, exp_rd.pop_front());
    end else begin
      note_error($sformatf("L2 request to %h at %0t ns has no matching input (cmd %0d)",
                           req.addr, $time, req.cmd));
    end
  endtask

  task automatic monitor_l2();
    bit              waiting;
    l2_req_payload_t held;
    waiting = 1'b0;
    forever begin
      @(posedge i_clk);
      if (!i_reset_n) begin
        waiting = 1'b0;
      end else begin
        if (waiting && (l2_req_valid !== 1'b1 || l2_req_payload !== held)) begin
          note_error($sformatf("Fail at %0t ns: L2 request changed while stalled", $time));
        end
        if (l2_req_valid && l2_req_ready) begin
          take_request(l2_req_payload);
        end
        waiting = l2_req_valid && !l2_req_ready;
        held    = l2_req_payload;
      end
    end
  endtask

  function automatic evict_payload_t rand_evict();
    evict_payload_t e;
    e.paddr = $urandom & 32'hffff_fff0;  // line aligned
    e.data  = {$urandom, $urandom, $urandom, $urandom};
    return e;
  endfunction

  function automatic miss_payload_t rand_miss(int id);
    miss_payload_t m;
    m.paddr   = $urandom & 32'hffff_fff0;
    m.miss_id = ID_W'(id);
    return m;
  endfunction

  // called on a falling edge, returns on a falling edge
  task automatic push_evict(evict_payload_t p);
    evict_valid   = 1'b1;
    evict_payload = p;
    while (!evict_ready) @(negedge i_clk);
    exp_wr.push_back(p);
    @(negedge i_clk);
    evict_valid = 1'b0;
  endtask

  task automatic push_miss(miss_payload_t p);
    miss_valid   = 1'b1;
    miss_payload = p;
    while (!miss_ready) @(negedge i_clk);
    exp_rd.push_back(p);
    @(negedge i_clk);
    miss_valid = 1'b0;
  endtask

  task automatic stall_until_drained(int ready_pct);
    while (!(feed_done && exp_wr.size() == 0 && exp_rd.size() == 0)) begin
      l2_req_ready = ($urandom % 100) < ready_pct;
      @(negedge i_clk);
    end
    l2_req_ready = 1'b1;
    repeat (4) @(negedge i_clk);  // room for a duplicate to show up
  endtask

  task automatic run_traffic(int n_wr, int n_rd, int ready_pct);
    feed_done = 1'b0;
    fork
      begin
        fork
          repeat (n_wr) push_evict(rand_evict());
          for (int i = 0; i < n_rd; i++) push_miss(rand_miss(i));
        join
        feed_done = 1'b1;
      end
      stall_until_drained(ready_pct);
    join
  endtask

  task automatic finish_test(string name, int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    i_reset_n = 1'b0;
    repeat (8) begin
      @(negedge i_clk);
      check_flag(l2_req_valid, 1'b0, "l2_req_valid during reset");
    end
    i_reset_n = 1'b1;
    @(negedge i_clk);
    check_flag(l2_req_valid, 1'b0, "l2_req_valid after reset");
    check_flag(evict_ready, 1'b1, "evict_ready after reset");
    check_flag(miss_ready, 1'b1, "miss_ready after reset");
    finish_test("reset", e0);
  endtask

  task automatic test_single();
    int e0;
    e0 = errors;
    run_traffic(1, 0, 100);
    finish_test("single eviction", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    e0 = errors;
    l2_req_ready = 1'b0;
    repeat (3) push_evict(rand_evict());  // two buffer entries plus the skid
    repeat (4) begin
      check_flag(evict_ready, 1'b0, "evict_ready with buffer and skid full");
      @(negedge i_clk);
    end
    feed_done = 1'b1;
    stall_until_drained(50);
    run_traffic(5, 0, 50);
    finish_test("back-pressure", e0);
  endtask

  task automatic test_refill();
    int e0;
    e0 = errors;
    run_traffic(0, 6, 100);
    finish_test("refill reads", e0);
  endtask

  task automatic test_mixed();
    int e0;
    e0 = errors;
    run_traffic(12, 12, 50);
    finish_test("mixed traffic", e0);
  endtask

  initial begin
    void'($urandom(83));
    i_reset_n     = 1'b0;
    evict_valid   = 1'b0;
    evict_payload = '0;
    miss_valid    = 1'b0;
    miss_payload  = '0;
    l2_req_ready  = 1'b0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    feed_done     = 1'b0;
    fork
      monitor_l2();
    join_none
    test_reset();
    test_single();
    test_backpressure();
    test_refill();
    test_mixed();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+common
common/lsu_pkg.sv
src/evict_buffer.sv
src/store_requestor.sv
src/refill_requestor.sv
src/l2_req_arbiter.sv
src/l1d_writeback_top.sv
verification/tb_l1d_writeback.sv

// ==== Makefile ====
TOP := tb_l1d_writeback

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	@if grep -q "Test failures found" sim.log; then \
	  echo "simulation FAILED"; exit 1; \
	elif ! grep -q "All tests passed!" sim.log; then \
	  echo "simulation ended early"; exit 1; \
	else \
	  echo "simulation ok"; \
	fi

clean:
	rm -rf obj_dir sim.log
